//--- include/tile_consts.svh
// tile serializer constants

`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// ====================
// bitplane geometry
// ====================

// bits in one bitplane byte
`define PLANE_W 8

// bitplanes per tile row, also the pixel colour width
`define PLANE_CNT 3

// one pixel per plane bit
`define ROW_PIXELS `PLANE_W

// ====================
// buffering and timing
// ====================

// queued rows, power of two
`define ROW_FIFO_DEPTH 4

// clk cycles per pixel, 48 MHz down to 6 MHz
`define PIX_DIV 8

`endif

//--- rtl/tile_pkg.sv
// tile serializer types

`include "tile_consts.svh"

package tile_pkg;

   // ====================
   // pixel data
   // ====================

   // one bitplane byte
   typedef logic [`PLANE_W-1:0] plane_t;

   // colour index, bit n comes from plane n
   typedef logic [`PLANE_CNT-1:0] pixel_t;

   // ====================
   // row and timing
   // ====================

   // flip on top, then plane2 down to plane0
   typedef struct packed {
      logic   flip;
      plane_t plane2;
      plane_t plane1;
      plane_t plane0;
   } tile_row_t;

   // pixel divider count
   typedef logic [$clog2(`PIX_DIV)-1:0] pix_cnt_t;

endpackage

//--- rtl/pixel_clock_enable.sv
// pixel clock enable divider

`timescale 1ns/100ps
`include "tile_consts.svh"

module pixel_clock_enable
   import tile_pkg::*;
(
   input  logic clk,
   input  logic CR,
   output logic pix_en_o
);

   // last count before wrap
   localparam pix_cnt_t LAST_CNT = pix_cnt_t'(`PIX_DIV - 1);

   pix_cnt_t div_cnt_q;

   // modulo PIX_DIV counter
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         div_cnt_q <= '0;
      end
      else if (div_cnt_q == LAST_CNT)
      begin
         div_cnt_q <= '0;
      end
      else
      begin
         div_cnt_q <= div_cnt_q + 1'b1;
      end
   end

   // one clk wide strobe at the top of the count
   assign pix_en_o = (div_cnt_q == LAST_CNT);

endmodule

//--- rtl/plane_loader.sv
// four-phase plane loader

`timescale 1ns/100ps
`include "tile_consts.svh"

module plane_loader
   import tile_pkg::*;
(
   input  logic      clk,
   input  logic      CR,
   input  logic      req_i,
   input  plane_t    data_i,
   input  logic      flip_i,
   output logic      ack_o,
   input  logic      full_i,
   output logic      push_o,
   output tile_row_t row_o
);

   localparam int CNT_W = $clog2(`PLANE_CNT);
   localparam logic [CNT_W-1:0] LAST_PLANE = CNT_W'(`PLANE_CNT - 1);

   logic [CNT_W-1:0] plane_cnt_q;
   logic             pending_q;
   logic             store;
   tile_row_t        row_q;

   // new request, no ack outstanding, no row stuck behind a full FIFO
   assign store = req_i & ~ack_o & ~pending_q;

   // ====================
   // handshake and row state
   // ====================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         ack_o       <= 1'b0;
         plane_cnt_q <= '0;
         pending_q   <= 1'b0;
      end
      else
      begin
         // ack high until req seen low
         if (store)
            ack_o <= 1'b1;
         else if (ack_o && !req_i)
            ack_o <= 1'b0;

         if (store)
            plane_cnt_q <= (plane_cnt_q == LAST_PLANE) ? '0 : plane_cnt_q + 1'b1;

         // row complete after plane2, held until the FIFO takes it
         if (store && plane_cnt_q == LAST_PLANE)
            pending_q <= 1'b1;
         else if (pending_q && !full_i)
            pending_q <= 1'b0;
      end
   end

   // steer byte into its plane slot
   always_ff @(posedge clk)
   begin
      if (store)
      begin
         if (plane_cnt_q == LAST_PLANE)
         begin
            row_q.plane2 <= data_i;
            row_q.flip   <= flip_i;
         end
         else if (plane_cnt_q == '0)
            row_q.plane0 <= data_i;
         else
            row_q.plane1 <= data_i;
      end
   end

   assign push_o = pending_q;
   assign row_o  = row_q;

endmodule

//--- rtl/row_fifo.sv
// tile row FIFO

`timescale 1ns/100ps
`include "tile_consts.svh"

module row_fifo
   import tile_pkg::*;
(
   input  logic      clk,
   input  logic      CR,
   input  logic      push_i,
   input  tile_row_t row_i,
   output logic      full_o,
   input  logic      pop_i,
   output tile_row_t row_o,
   output logic      empty_o
);

   localparam int AW = $clog2(`ROW_FIFO_DEPTH);
   localparam logic [AW:0] DEPTH = (AW+1)'(`ROW_FIFO_DEPTH);

   tile_row_t     mem [`ROW_FIFO_DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;
   logic          do_push;
   logic          do_pop;

   // flags straight from occupancy
   assign full_o  = (count_q == DEPTH);
   assign empty_o = (count_q == '0);

   // overflow and underflow requests dropped here
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   // ====================
   // pointers and count
   // ====================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         // power of two depth, pointers wrap on their own
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;

         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr_q] <= row_i;
   end

   // head row, no read latency
   assign row_o = mem[rd_ptr_q];

endmodule

//--- rtl/plane_shifter.sv
// bitplane pixel shifter

`timescale 1ns/100ps
`include "tile_consts.svh"

module plane_shifter
   import tile_pkg::*;
(
   input  logic      clk,
   input  logic      CR,
   input  logic      pix_en_i,
   input  tile_row_t row_i,
   input  logic      empty_i,
   output logic      pop_o,
   output pixel_t    pixel_o,
   output logic      pixel_valid_o
);

   localparam int LEFT_W = $clog2(`ROW_PIXELS);
   localparam logic [LEFT_W-1:0] LOAD_LEFT = LEFT_W'(`ROW_PIXELS - 1);

   plane_t            p2_q;
   plane_t            p1_q;
   plane_t            p0_q;
   logic              flip_q;
   logic [LEFT_W-1:0] left_q;
   logic              busy;
   logic              load;
   logic              shift;

   // move one place toward the output end, like 74194 left/right modes
   function automatic plane_t step_plane(input plane_t p, input logic flip);
      step_plane = flip ? {1'b0, p[`PLANE_W-1:1]} : {p[`PLANE_W-2:0], 1'b0};
   endfunction

   // bits at the output end, msb end unless flipped
   function automatic pixel_t end_pixel(input plane_t p2, input plane_t p1,
                                        input plane_t p0, input logic flip);
      if (flip)
         end_pixel = {p2[0], p1[0], p0[0]};
      else
         end_pixel = {p2[`PLANE_W-1], p1[`PLANE_W-1], p0[`PLANE_W-1]};
   endfunction

   assign busy  = (left_q != '0);
   assign load  = pix_en_i & ~busy & ~empty_i;
   assign shift = pix_en_i & busy;

   // pop in the same enable that emits the first pixel
   assign pop_o = load;

   // ====================
   // output and count
   // ====================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         left_q        <= '0;
         pixel_o       <= '0;
         pixel_valid_o <= 1'b0;
      end
      else
      begin
         pixel_valid_o <= load | shift;
         if (load)
         begin
            left_q  <= LOAD_LEFT;
            pixel_o <= end_pixel(row_i.plane2, row_i.plane1, row_i.plane0, row_i.flip);
         end
         else if (shift)
         begin
            left_q  <= left_q - 1'b1;
            pixel_o <= end_pixel(p2_q, p1_q, p0_q, flip_q);
         end
      end
   end

   // first pixel already taken, load the planes pre-shifted
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         p2_q   <= step_plane(row_i.plane2, row_i.flip);
         p1_q   <= step_plane(row_i.plane1, row_i.flip);
         p0_q   <= step_plane(row_i.plane0, row_i.flip);
         flip_q <= row_i.flip;
      end
      else if (shift)
      begin
         p2_q <= step_plane(p2_q, flip_q);
         p1_q <= step_plane(p1_q, flip_q);
         p0_q <= step_plane(p0_q, flip_q);
      end
   end

endmodule

//--- rtl/tile_serializer_top.sv
// tile row pixel serializer

`timescale 1ns/100ps

module tile_serializer_top
   import tile_pkg::*;
(
   input  logic   clk,
   input  logic   CR,
   input  logic   req_i,
   input  plane_t data_i,
   input  logic   flip_i,
   output logic   ack_o,
   output pixel_t pixel_o,
   output logic   pixel_valid_o
);

   logic      pix_en;
   logic      push;
   logic      full;
   logic      pop;
   logic      empty;
   tile_row_t load_row;
   tile_row_t head_row;

   // pixel rate strobe
   pixel_clock_enable u_pix_en (
      .clk      (clk),
      .CR       (CR),
      .pix_en_o (pix_en)
   );

   // ====================
   // host side
   // ====================
   plane_loader u_loader (
      .clk    (clk),
      .CR     (CR),
      .req_i  (req_i),
      .data_i (data_i),
      .flip_i (flip_i),
      .ack_o  (ack_o),
      .full_i (full),
      .push_o (push),
      .row_o  (load_row)
   );

   row_fifo u_fifo (
      .clk     (clk),
      .CR      (CR),
      .push_i  (push),
      .row_i   (load_row),
      .full_o  (full),
      .pop_i   (pop),
      .row_o   (head_row),
      .empty_o (empty)
   );

   // ====================
   // pixel side
   // ====================
   plane_shifter u_shifter (
      .clk           (clk),
      .CR            (CR),
      .pix_en_i      (pix_en),
      .row_i         (head_row),
      .empty_i       (empty),
      .pop_o         (pop),
      .pixel_o       (pixel_o),
      .pixel_valid_o (pixel_valid_o)
   );

endmodule

//--- bench/tile_serializer_asserts.sv
// tile serializer assertions

`timescale 1ns/100ps

module tile_serializer_asserts (
   input logic clk,
   input logic CR,
   input logic req_i,
   input logic ack_i,
   input logic pixel_valid_i
);

   // assertion failures so far
   int fail_cnt = 0;

   // ====================
   // host handshake
   // ====================

   // ack only answers a request seen the cycle before
   ack_rise_a : assert property (
      @(posedge clk) disable iff (!CR)
      $rose(ack_i) |-> $past(req_i)
   )
   else
   begin
      $error("ack_o rose while req_i was low");
      fail_cnt = fail_cnt + 1;
   end

   // ack drops only once the host has let go of req
   ack_fall_a : assert property (
      @(posedge clk) disable iff (!CR)
      $fell(ack_i) |-> !$past(req_i)
   )
   else
   begin
      $error("ack_o fell while req_i was still high");
      fail_cnt = fail_cnt + 1;
   end

   // ====================
   // pixel strobe
   // ====================

   // one clk wide and never back to back
   valid_pulse_a : assert property (
      @(posedge clk) disable iff (!CR)
      pixel_valid_i |=> !pixel_valid_i
   )
   else
   begin
      $error("pixel_valid_o high for two cycles in a row");
      fail_cnt = fail_cnt + 1;
   end

endmodule

//--- bench/tile_serializer_tb.sv
// tile serializer testbench

`timescale 1ns/100ps
`include "tile_consts.svh"

module tile_serializer_tb
   import tile_pkg::*;
();

   localparam int N_ROWS = 8;
   localparam int TIMEOUT_CYCLES = N_ROWS * (`ROW_PIXELS * `PIX_DIV + 3 * 20) * 2;

   logic        clk;
   logic        CR;
   logic        req_i;
   plane_t      data_i;
   logic        flip_i;
   logic        ack_o;
   pixel_t      pixel_o;
   logic        pixel_valid_o;
   int          cycle_cnt = 0;
   int          rows_sent = 0;
   logic [31:0] rng_state = 32'he3ee;

   // ====================
   // stimulus table
   // ====================
   string  row_name  [N_ROWS] = '{"ramp_plain", "ramp_flip", "edge_flip", "edge_plain",
                                  "mixed_plain", "ones_flip", "mid_flip", "mid_plain"};
   plane_t row_p0    [N_ROWS] = '{8'hAA, 8'hAA, 8'h01, 8'h01, 8'h0F, 8'hFF, 8'h10, 8'h10};
   plane_t row_p1    [N_ROWS] = '{8'hCC, 8'hCC, 8'h00, 8'h00, 8'h3C, 8'hFF, 8'h04, 8'h04};
   plane_t row_p2    [N_ROWS] = '{8'hF0, 8'hF0, 8'h80, 8'h80, 8'h81, 8'hFF, 8'h40, 8'h40};
   logic   row_flip  [N_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
   // tail rows go with no idle gap so the FIFO fills
   logic   row_burst [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};

   // pixels in output order
   pixel_t exp_pix [N_ROWS][`ROW_PIXELS] = '{
      '{3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0},
      '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7},
      '{3'd1, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd4},
      '{3'd4, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd1},
      '{3'd4, 3'd0, 3'd2, 3'd2, 3'd3, 3'd3, 3'd1, 3'd5},
      '{3'd7, 3'd7, 3'd7, 3'd7, 3'd7, 3'd7, 3'd7, 3'd7},
      '{3'd0, 3'd0, 3'd2, 3'd0, 3'd1, 3'd0, 3'd4, 3'd0},
      '{3'd0, 3'd4, 3'd0, 3'd1, 3'd0, 3'd2, 3'd0, 3'd0}
   };

   tile_serializer_top UUT (
      .clk           (clk),
      .CR            (CR),
      .req_i         (req_i),
      .data_i        (data_i),
      .flip_i        (flip_i),
      .ack_o         (ack_o),
      .pixel_o       (pixel_o),
      .pixel_valid_o (pixel_valid_o)
   );

   bind tile_serializer_top tile_serializer_asserts u_asserts (
      .clk           (clk),
      .CR            (CR),
      .req_i         (req_i),
      .ack_i         (ack_o),
      .pixel_valid_i (pixel_valid_o)
   );

   // 20 ns period
   initial
   begin
      clk = 1'b0;
   end

   always #10 clk = ~clk;

   // ====================
   // helpers
   // ====================
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_pixel(input string name, input pixel_t exp_val, input pixel_t act_val);
      if (act_val !== exp_val)
         abort_run($sformatf("error: %s expected %0d actual %0d", name, exp_val, act_val));
   endtask

   task automatic check_flag(input string name, input logic exp_val, input logic act_val);
      if (act_val !== exp_val)
         abort_run($sformatf("error: %s expected %0b actual %0b", name, exp_val, act_val));
   endtask

   task automatic idle_gap(input logic burst);
      int gap;
      gap = 0;
      if (!burst)
      begin
         rng_state = lcg_next(rng_state);
         gap = int'(rng_state[19:16]);
      end
      repeat (gap) @(posedge clk);
   endtask

   // one four-phase transfer
   task automatic send_byte(input plane_t data, input logic flip);
      @(posedge clk);
      req_i  <= 1'b1;
      data_i <= data;
      flip_i <= flip;
      @(negedge clk);
      while (ack_o !== 1'b1)
         @(negedge clk);
      @(posedge clk);
      req_i <= 1'b0;
      @(negedge clk);
      while (ack_o !== 1'b0)
         @(negedge clk);
   endtask

   task automatic send_row(input int idx);
      idle_gap(row_burst[idx]);
      send_byte(row_p0[idx], row_flip[idx]);
      idle_gap(row_burst[idx]);
      send_byte(row_p1[idx], row_flip[idx]);
      idle_gap(row_burst[idx]);
      send_byte(row_p2[idx], row_flip[idx]);
      @(posedge clk);
      rows_sent <= rows_sent + 1;
   endtask

   // cycle count and run limit
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         abort_run("timeout: the pixels of all rows did not come out in time");
      else if (UUT.u_asserts.fail_cnt != 0)
         abort_run("a handshake or pixel strobe assertion failed");
   end

   // ====================
   // host side
   // ====================
   initial
   begin
      CR     = 1'b0;
      req_i  = 1'b0;
      data_i = '0;
      flip_i = 1'b0;
      @(negedge clk);
      check_flag("reset ack_o", 1'b0, ack_o);
      check_flag("reset pixel_valid_o", 1'b0, pixel_valid_o);
      check_pixel("reset pixel_o", '0, pixel_o);
      @(posedge clk);
      CR <= 1'b1;
      // first clock edge out of reset
      @(posedge clk);
      @(negedge clk);
      check_flag("post reset ack_o", 1'b0, ack_o);
      check_flag("post reset pixel_valid_o", 1'b0, pixel_valid_o);
      check_pixel("post reset pixel_o", '0, pixel_o);
      for (int r = 0; r < N_ROWS; r++)
         send_row(r);
   end

   // ====================
   // pixel side
   // ====================
   initial
   begin
      int    last_cyc;
      logic  next_ready;
      string tag;
      last_cyc   = 0;
      next_ready = 1'b0;
      @(posedge CR);
      for (int r = 0; r < N_ROWS; r++)
      begin
         for (int k = 0; k < `ROW_PIXELS; k++)
         begin
            @(negedge clk);
            while (pixel_valid_o !== 1'b1)
               @(negedge clk);
            tag = $sformatf("%s pixel %0d", row_name[r], k);
            check_pixel(tag, exp_pix[r][k], pixel_o);
            // gap-free once the next row was handed over in time
            if (k > 0 || (r > 0 && next_ready))
               check_flag({tag, " spacing"}, 1'b1, (cycle_cnt - last_cyc) == `PIX_DIV);
            last_cyc = cycle_cnt;
            if (k == `ROW_PIXELS - 1)
               next_ready = (rows_sent > r + 1);
         end
      end
      // nothing duplicated after the last row
      repeat (3 * `PIX_DIV)
      begin
         @(negedge clk);
         check_flag("no extra pixel", 1'b0, pixel_valid_o);
      end
      if (UUT.u_asserts.fail_cnt != 0)
         abort_run("a handshake or pixel strobe assertion failed");
      else
      begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule

//--- vlog.f
+incdir+include
rtl/tile_pkg.sv
rtl/pixel_clock_enable.sv
rtl/plane_loader.sv
rtl/row_fifo.sv
rtl/plane_shifter.sv
rtl/tile_serializer_top.sv
bench/tile_serializer_asserts.sv
bench/tile_serializer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tile serializer simulation with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tile_serializer_tb
OBJ_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -Mdir "$OBJ_DIR"; then
   echo "build failed"
   exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ "$run_status" -ne 0 ]; then
   echo "simulation exited with status $run_status"
fi

if grep -qF "*** TEST PASSED ***" "$LOG" && [ "$run_status" -eq 0 ]; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $LOG"
   exit 1
fi
